//--- logic/matrix_params.svh
`ifndef MATRIX_PARAMS_SVH
`define MATRIX_PARAMS_SVH

// ========================================
// Memory geometry
// ========================================
`define MATRIX_ADDR_WIDTH 12
`define MATRIX_DATA_WIDTH 16
`define MATRIX_MEM_DEPTH  4096

// ========================================
// Command fields
// ========================================
`define MATRIX_DIM_WIDTH  6   // Row and column counts of a source matrix.
`define MATRIX_WIN_WIDTH  4   // Window height and width.

// One command word, as presented at the host handshake.
`define MATRIX_CMD_WIDTH  48

`endif

//--- logic/matrix_pkg.sv
`include "matrix_params.svh"

package matrix_pkg;

    typedef enum logic {
        op_maxpool = 1'b0,
        op_relu    = 1'b1
    } matrix_op_e;

    // The opcode sits in the top bit of both views so it decodes the same either way.
    typedef struct packed {
        matrix_op_e                   opcode;
        logic [`MATRIX_ADDR_WIDTH-1:0] src_address;
        logic [`MATRIX_ADDR_WIDTH-1:0] dest_address;
        logic [`MATRIX_DIM_WIDTH-1:0]  src_rows;
        logic [`MATRIX_DIM_WIDTH-1:0]  src_cols;
        logic [`MATRIX_WIN_WIDTH-1:0]  win_rows;
        logic [`MATRIX_WIN_WIDTH-1:0]  win_cols;
        logic [2:0]                    spare;
    } pool_cmd_t;

    typedef struct packed {
        matrix_op_e                   opcode;
        logic [`MATRIX_ADDR_WIDTH-1:0] src_address;
        logic [`MATRIX_ADDR_WIDTH-1:0] dest_address;
        logic [`MATRIX_ADDR_WIDTH-1:0] word_count;
        logic [10:0]                   spare;
    } relu_cmd_t;

    typedef union packed {
        pool_cmd_t pool;
        relu_cmd_t relu;
    } matrix_cmd_u;

endpackage

//--- logic/mem_port_if.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

// Request/response port into the scratch memory.
// Reads return one cycle after the address is presented.
interface mem_port_if;
    logic [`MATRIX_ADDR_WIDTH-1:0] address;
    logic [`MATRIX_DATA_WIDTH-1:0] writedata;
    logic                          write_en;
    logic [`MATRIX_DATA_WIDTH-1:0] readdata;

    modport engine (
        output address,
        output writedata,
        output write_en,
        input  readdata
    );

    modport memory (
        input  address,
        input  writedata,
        input  write_en,
        output readdata
    );
endinterface

//--- logic/matrix_memory.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_memory (
    input  logic                          clk,
    mem_port_if.memory                    port,
    input  logic [`MATRIX_ADDR_WIDTH-1:0] host_address,
    input  logic [`MATRIX_DATA_WIDTH-1:0] host_writedata,
    input  logic                          host_write_en,
    output logic [`MATRIX_DATA_WIDTH-1:0] host_readdata
);
    logic [`MATRIX_DATA_WIDTH-1:0] mem [0:`MATRIX_MEM_DEPTH-1];

    // ========================================
    // Storage
    // ========================================
    // Both ports live in one process; reads see the contents from before the edge.
    always_ff @(posedge clk) begin
        if (port.write_en) begin
            mem[port.address] <= port.writedata;
        end
        if (host_write_en) begin
            mem[host_address] <= host_writedata;
        end
        port.readdata <= mem[port.address];
        host_readdata <= mem[host_address];
    end

    // A collision between the engine side and the host is a usage error.
    assert property (@(posedge clk)
        !(port.write_en && host_write_en && (port.address == host_address)))
    else $error("matrix_memory: both ports write address %0h", host_address);

endmodule

//--- logic/matrix_maxpool.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_maxpool (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  matrix_pkg::pool_cmd_t cmd,
    mem_port_if.engine            port,
    output logic                  done
);
    localparam int win_pad  = `MATRIX_DIM_WIDTH - `MATRIX_WIN_WIDTH;
    localparam int addr_pad = `MATRIX_ADDR_WIDTH - `MATRIX_DIM_WIDTH;
    localparam logic [`MATRIX_DIM_WIDTH-1:0]  dim_one  = 1;
    localparam logic [`MATRIX_ADDR_WIDTH-1:0] addr_one = 1;

    typedef enum logic [1:0] {st_idle, st_read, st_write} state_t;

    state_t                        state;
    logic                          rd_valid_q;  // A read was issued last cycle.
    logic [`MATRIX_DIM_WIDTH-1:0]  elem_row_cnt;
    logic [`MATRIX_DIM_WIDTH-1:0]  elem_col_cnt;
    logic [`MATRIX_DIM_WIDTH-1:0]  blk_row;
    logic [`MATRIX_DIM_WIDTH-1:0]  blk_col;
    logic [`MATRIX_DIM_WIDTH:0]    next_blk_row;
    logic [`MATRIX_DIM_WIDTH:0]    next_blk_col;
    logic [`MATRIX_DIM_WIDTH-1:0]  win_rows_ext;
    logic [`MATRIX_DIM_WIDTH-1:0]  win_cols_ext;
    logic [`MATRIX_DIM_WIDTH-1:0]  elem_row;
    logic [`MATRIX_DIM_WIDTH-1:0]  elem_col;
    logic [`MATRIX_ADDR_WIDTH-1:0] row_offset;
    logic [`MATRIX_ADDR_WIDTH-1:0] read_address;
    logic [`MATRIX_ADDR_WIDTH-1:0] dest_ptr;
    logic [`MATRIX_DATA_WIDTH-1:0] max_q;
    logic [`MATRIX_DATA_WIDTH-1:0] data_max;
    logic                          last_col;
    logic                          last_row;
    logic                          last_block;

    // ========================================
    // Address generation
    // ========================================
    assign win_rows_ext = {{win_pad{1'b0}}, cmd.win_rows};
    assign win_cols_ext = {{win_pad{1'b0}}, cmd.win_cols};
    assign elem_row     = blk_row + elem_row_cnt;
    assign elem_col     = blk_col + elem_col_cnt;
    assign row_offset   = {{addr_pad{1'b0}}, elem_row} * {{addr_pad{1'b0}}, cmd.src_cols};
    assign read_address = cmd.src_address + row_offset + {{addr_pad{1'b0}}, elem_col};

    assign last_col     = (elem_col_cnt == win_cols_ext - dim_one);
    assign last_row     = (elem_row_cnt == win_rows_ext - dim_one);
    assign next_blk_row = {1'b0, blk_row} + {1'b0, win_rows_ext};
    assign next_blk_col = {1'b0, blk_col} + {1'b0, win_cols_ext};
    assign last_block   = (next_blk_col == {1'b0, cmd.src_cols}) &&
                          (next_blk_row == {1'b0, cmd.src_rows});

    // Compare the word that came back for last cycle's read.
    assign data_max = (rd_valid_q && (port.readdata > max_q)) ? port.readdata : max_q;

    assign port.address   = (state == st_write) ? dest_ptr : read_address;
    assign port.writedata = data_max;

    // ========================================
    // Control
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_idle;
            rd_valid_q    <= 1'b0;
            port.write_en <= 1'b0;
            done          <= 1'b0;
            elem_row_cnt  <= '0;
            elem_col_cnt  <= '0;
            blk_row       <= '0;
            blk_col       <= '0;
        end else begin
            done          <= 1'b0;
            rd_valid_q    <= (state == st_read);
            port.write_en <= (state == st_read) && last_col && last_row;  // Window is complete.
            case (state)
                st_idle: begin
                    if (start) begin
                        elem_row_cnt <= '0;
                        elem_col_cnt <= '0;
                        blk_row      <= '0;
                        blk_col      <= '0;
                        state        <= st_read;
                    end
                end
                st_read: begin
                    if (last_col) begin
                        elem_col_cnt <= '0;
                        if (last_row) begin
                            elem_row_cnt <= '0;
                            state        <= st_write;
                        end else begin
                            elem_row_cnt <= elem_row_cnt + dim_one;
                        end
                    end else begin
                        elem_col_cnt <= elem_col_cnt + dim_one;
                    end
                end
                st_write: begin
                    if (last_block) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end else if (next_blk_col == {1'b0, cmd.src_cols}) begin
                        blk_col <= '0;
                        blk_row <= next_blk_row[`MATRIX_DIM_WIDTH-1:0];
                        state   <= st_read;
                    end else begin
                        blk_col <= next_blk_col[`MATRIX_DIM_WIDTH-1:0];
                        state   <= st_read;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && start) begin
            max_q    <= '0;
            dest_ptr <= cmd.dest_address;
        end else if (state == st_read) begin
            max_q <= data_max;
        end else if (state == st_write) begin
            max_q    <= '0;  // Next window starts from scratch.
            dest_ptr <= dest_ptr + addr_one;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (state == st_idle) |-> !port.write_en)
    else $error("matrix_maxpool: write while idle");

endmodule

//--- logic/matrix_relu.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_relu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  matrix_pkg::relu_cmd_t cmd,
    mem_port_if.engine            port,
    output logic                  done
);
    localparam logic [`MATRIX_ADDR_WIDTH-1:0] addr_one = 1;

    typedef enum logic [1:0] {st_idle, st_read, st_write} state_t;

    state_t                        state;
    logic [`MATRIX_ADDR_WIDTH-1:0] offset;
    logic [`MATRIX_ADDR_WIDTH-1:0] write_offset;

    // Read a word, then write it back one cycle later when the data is in.
    assign port.address   = (state == st_write) ? cmd.dest_address + offset
                                                : cmd.src_address + offset;
    assign port.writedata = port.readdata[`MATRIX_DATA_WIDTH-1] ? '0 : port.readdata;
    assign port.write_en  = (state == st_write);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_idle;
            offset <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) begin
                        offset <= '0;
                        state  <= st_read;
                    end
                end
                st_read: state <= st_write;
                st_write: begin
                    if (offset == cmd.word_count - addr_one) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end else begin
                        offset <= offset + addr_one;
                        state  <= st_read;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // ========================================
    // Checks
    // ========================================
    assign write_offset = port.address - cmd.dest_address;

    assert property (@(posedge clk) disable iff (reset)
        port.write_en |-> (write_offset < cmd.word_count))
    else $error("matrix_relu: write outside destination at %0h", port.address);

endmodule

//--- logic/matrix_sequencer.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         cmd_valid,
    output logic                         cmd_ready,
    input  logic [`MATRIX_CMD_WIDTH-1:0] cmd_word,
    output matrix_pkg::pool_cmd_t        pool_cmd,
    output matrix_pkg::relu_cmd_t        relu_cmd,
    output logic                         pool_start,
    output logic                         relu_start,
    input  logic                         pool_done,
    input  logic                         relu_done,
    mem_port_if.memory                   pool_port,
    mem_port_if.memory                   relu_port,
    mem_port_if.engine                   mem_port,
    output logic                         busy,
    output logic                         done
);
    import matrix_pkg::*;

    matrix_cmd_u cmd_in;
    matrix_cmd_u cmd_q;
    logic        use_pool;
    logic        accept;
    logic        engine_done;

    assign cmd_in      = cmd_word;
    assign accept      = cmd_valid && cmd_ready;
    assign use_pool    = (cmd_q.pool.opcode == op_maxpool);
    assign engine_done = use_pool ? pool_done : relu_done;

    // Both views come from the same held word and stay put while busy.
    assign pool_cmd = cmd_q.pool;
    assign relu_cmd = cmd_q.relu;

    // ========================================
    // Command handshake
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_q      <= '0;
            cmd_ready  <= 1'b1;
            busy       <= 1'b0;
            done       <= 1'b0;
            pool_start <= 1'b0;
            relu_start <= 1'b0;
        end else begin
            done       <= 1'b0;
            pool_start <= 1'b0;
            relu_start <= 1'b0;
            if (accept) begin
                cmd_q      <= cmd_in;
                cmd_ready  <= 1'b0;
                busy       <= 1'b1;
                pool_start <= (cmd_in.pool.opcode == op_maxpool);
                relu_start <= (cmd_in.pool.opcode == op_relu);
            end else if (busy && engine_done) begin
                cmd_ready <= 1'b1;
                busy      <= 1'b0;
                done      <= 1'b1;
            end
        end
    end

    // ========================================
    // Memory steering
    // ========================================
    assign mem_port.address   = use_pool ? pool_port.address : relu_port.address;
    assign mem_port.writedata = use_pool ? pool_port.writedata : relu_port.writedata;
    assign mem_port.write_en  = use_pool ? pool_port.write_en : relu_port.write_en;

    assign pool_port.readdata = mem_port.readdata;  // Only the active engine looks at it.
    assign relu_port.readdata = mem_port.readdata;

    assert property (@(posedge clk) disable iff (reset) !(cmd_ready && busy))
    else $error("matrix_sequencer: ready while busy");

endmodule

//--- logic/matrix_unit.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    input  logic [`MATRIX_CMD_WIDTH-1:0]  cmd_word,
    input  logic [`MATRIX_ADDR_WIDTH-1:0] host_address,
    input  logic [`MATRIX_DATA_WIDTH-1:0] host_writedata,
    input  logic                          host_write_en,
    output logic [`MATRIX_DATA_WIDTH-1:0] host_readdata,
    output logic                          busy,
    output logic                          done
);
    import matrix_pkg::*;

    pool_cmd_t pool_cmd;
    relu_cmd_t relu_cmd;
    logic      pool_start;
    logic      relu_start;
    logic      pool_done;
    logic      relu_done;

    mem_port_if pool_port ();
    mem_port_if relu_port ();
    mem_port_if mem_port ();

    matrix_sequencer matrix_sequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_word   (cmd_word),
        .pool_cmd   (pool_cmd),
        .relu_cmd   (relu_cmd),
        .pool_start (pool_start),
        .relu_start (relu_start),
        .pool_done  (pool_done),
        .relu_done  (relu_done),
        .pool_port  (pool_port.memory),
        .relu_port  (relu_port.memory),
        .mem_port   (mem_port.engine),
        .busy       (busy),
        .done       (done)
    );

    matrix_maxpool matrix_maxpool_inst (
        .clk   (clk),
        .reset (reset),
        .start (pool_start),
        .cmd   (pool_cmd),
        .port  (pool_port.engine),
        .done  (pool_done)
    );

    matrix_relu matrix_relu_inst (
        .clk   (clk),
        .reset (reset),
        .start (relu_start),
        .cmd   (relu_cmd),
        .port  (relu_port.engine),
        .done  (relu_done)
    );

    matrix_memory matrix_memory_inst (
        .clk            (clk),
        .port           (mem_port.memory),
        .host_address   (host_address),
        .host_writedata (host_writedata),
        .host_write_en  (host_write_en),
        .host_readdata  (host_readdata)
    );

endmodule

//--- bench/matrix_unit_tb.sv
`timescale 1ns/1ps
`include "matrix_params.svh"

module matrix_unit_tb;
    import matrix_pkg::*;

    localparam int timeout_cycles = 4000;

    logic                          clk = 1'b0;
    logic                          reset;
    logic                          cmd_valid;
    logic                          cmd_ready;
    logic [`MATRIX_CMD_WIDTH-1:0]  cmd_word;
    logic [`MATRIX_ADDR_WIDTH-1:0] host_address;
    logic [`MATRIX_DATA_WIDTH-1:0] host_writedata;
    logic                          host_write_en;
    logic [`MATRIX_DATA_WIDTH-1:0] host_readdata;
    logic                          busy;
    logic                          done;

    logic [`MATRIX_DATA_WIDTH-1:0] model_mem [0:`MATRIX_MEM_DEPTH-1];
    integer seed        = 6209;
    int     error_count = 0;
    int     check_count = 0;
    int     done_count  = 0;
    bit     run_over    = 1'b0;

    matrix_unit matrix_unit_inst (
        .clk            (clk),
        .reset          (reset),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .cmd_word       (cmd_word),
        .host_address   (host_address),
        .host_writedata (host_writedata),
        .host_write_en  (host_write_en),
        .host_readdata  (host_readdata),
        .busy           (busy),
        .done           (done)
    );

    always #4 clk = ~clk;

    // ========================================
    // Reporting
    // ========================================
    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (!run_over) begin
            check_count++;
            if (actual !== expected) begin
                error_count++;
                $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual,
                         expected);
            end
        end
    endtask

    task automatic finish_run();
        if (!run_over) begin
            run_over = 1'b1;
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    endtask

    task automatic report_timeout(string what);
        error_count++;
        $display("Timeout: no %s within %0d cycles", what, timeout_cycles);
        finish_run();
    endtask

    function automatic int rand_range(int lo, int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    // ========================================
    // Golden model
    // ========================================
    task automatic model_maxpool(pool_cmd_t c);
        int br;
        int bc;
        int row;
        int col;
        int n;
        logic [`MATRIX_DATA_WIDTH-1:0] m;
        logic [`MATRIX_DATA_WIDTH-1:0] w;
        n = 0;
        for (br = 0; br < int'(c.src_rows) / int'(c.win_rows); br++) begin
            for (bc = 0; bc < int'(c.src_cols) / int'(c.win_cols); bc++) begin
                m = '0;
                for (row = br * int'(c.win_rows); row < (br + 1) * int'(c.win_rows); row++) begin
                    for (col = bc * int'(c.win_cols); col < (bc + 1) * int'(c.win_cols); col++) begin
                        w = model_mem[12'(int'(c.src_address) + row * int'(c.src_cols) + col)];
                        if (w > m) m = w;  // Unsigned compare.
                    end
                end
                model_mem[12'(int'(c.dest_address) + n)] = m;
                n++;
            end
        end
    endtask

    task automatic model_relu(relu_cmd_t c);
        int k;
        logic [`MATRIX_DATA_WIDTH-1:0] w;
        for (k = 0; k < int'(c.word_count); k++) begin
            w = model_mem[12'(int'(c.src_address) + k)];
            model_mem[12'(int'(c.dest_address) + k)] = w[`MATRIX_DATA_WIDTH-1] ? '0 : w;
        end
    endtask

    task automatic apply_model(logic [`MATRIX_CMD_WIDTH-1:0] word);
        matrix_cmd_u u;
        u = word;
        if (u.pool.opcode == op_maxpool) begin
            model_maxpool(u.pool);
        end else begin
            model_relu(u.relu);
        end
    endtask

    // Sources stay in the lower half and destinations in the upper half, so they never overlap.
    function automatic logic [`MATRIX_CMD_WIDTH-1:0] random_pool_cmd();
        pool_cmd_t c;
        c              = '0;
        c.opcode       = op_maxpool;
        c.win_rows     = 4'(rand_range(1, 5));
        c.win_cols     = 4'(rand_range(1, 5));
        c.src_rows     = 6'(int'(c.win_rows) * rand_range(1, 3));
        c.src_cols     = 6'(int'(c.win_cols) * rand_range(1, 3));
        c.src_address  = 12'(rand_range(0, 1791));
        c.dest_address = 12'(rand_range(2048, 3839));
        return c;
    endfunction

    function automatic logic [`MATRIX_CMD_WIDTH-1:0] random_relu_cmd();
        relu_cmd_t c;
        c              = '0;
        c.opcode       = op_relu;
        c.word_count   = 12'(rand_range(1, 200));
        c.src_address  = 12'(rand_range(0, 1791));
        c.dest_address = 12'(rand_range(2048, 3839));
        return c;
    endfunction

    // ========================================
    // Host port and handshake
    // ========================================
    task automatic load_memory();
        int a;
        for (a = 0; a < `MATRIX_MEM_DEPTH; a++) begin
            model_mem[a] = 16'($random(seed));
            @(posedge clk);
            host_address   <= 12'(a);
            host_writedata <= model_mem[a];
            host_write_en  <= 1'b1;
        end
        @(posedge clk);
        host_write_en <= 1'b0;
    endtask

    // Reads every word back, so stray writes outside a destination show up too.
    task automatic check_memory();
        int a;
        for (a = 0; a < `MATRIX_MEM_DEPTH; a++) begin
            @(posedge clk);
            host_address <= 12'(a);
            @(posedge clk);
            @(negedge clk);
            check_value($sformatf("mem[%0h]", a), 32'(host_readdata), 32'(model_mem[a]));
        end
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(negedge clk);
        while (!cmd_ready && n < timeout_cycles) begin
            n++;
            @(negedge clk);
        end
        if (cmd_ready) begin
            @(posedge clk);  // The transfer happens on this edge.
        end else begin
            report_timeout("command acceptance");
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (!done && n < timeout_cycles) begin
            check_value("cmd_ready", 32'(cmd_ready), 32'd0);
            check_value("busy", 32'(busy), 32'd1);
            n++;
            @(negedge clk);
        end
        if (done) begin
            done_count++;
            check_value("cmd_ready", 32'(cmd_ready), 32'd1);
            check_value("busy", 32'(busy), 32'd0);
        end else begin
            report_timeout("done pulse");
        end
    endtask

    task automatic execute(logic [`MATRIX_CMD_WIDTH-1:0] word);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_word  <= word;
        wait_accept();
        cmd_valid <= 1'b0;
        wait_done();
        apply_model(word);
    endtask

    // The second command is held under back-pressure while the first one runs.
    task automatic run_held_pair(logic [`MATRIX_CMD_WIDTH-1:0] first,
                                 logic [`MATRIX_CMD_WIDTH-1:0] second);
        int start_count;
        start_count = done_count;
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_word  <= first;
        wait_accept();
        cmd_word <= second;
        wait_done();
        apply_model(first);
        @(posedge clk);  // Ready rose with done, so the held word goes in here.
        cmd_valid <= 1'b0;
        wait_done();
        apply_model(second);
        repeat (40) begin
            @(negedge clk);
            if (done) done_count++;
        end
        check_value("done pulses", 32'(done_count - start_count), 32'd2);
        check_memory();
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int i;
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_word       = '0;
        host_address   = '0;
        host_writedata = '0;
        host_write_en  = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("cmd_ready", 32'(cmd_ready), 32'd1);
        check_value("busy", 32'(busy), 32'd0);
        check_value("done", 32'(done), 32'd0);

        load_memory();
        check_memory();
        for (i = 0; i < 4; i++) begin
            execute(random_pool_cmd());
            check_memory();
        end
        for (i = 0; i < 4; i++) begin
            execute(random_relu_cmd());
            check_memory();
        end
        run_held_pair(random_pool_cmd(), random_relu_cmd());

        // Back to back, alternating opcodes, each issued right after the last done.
        for (i = 0; i < 6; i++) begin
            execute((i % 2 == 0) ? random_pool_cmd() : random_relu_cmd());
        end
        check_memory();
        finish_run();
    end

endmodule

//--- matrix_unit.f
+incdir+logic
logic/matrix_pkg.sv
logic/mem_port_if.sv
logic/matrix_memory.sv
logic/matrix_maxpool.sv
logic/matrix_relu.sv
logic/matrix_sequencer.sv
logic/matrix_unit.sv
bench/matrix_unit_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = matrix_unit_tb
FILELIST  = matrix_unit.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulator exited with an error: $(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
